/* compile.f */
source/gparse_pkg.sv
source/char_decoder.sv
source/arg_parser.sv
source/linear_subparser_fsm.sv
source/move_result.sv
source/linear_parser_top.sv
testbench/linear_parser_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module linear_parser_tb \
	-o linear_parser_sim > sim.log 2>&1 \
	&& ./obj_dir/linear_parser_sim >> sim.log 2>&1 \
	|| echo "Simulation finished: FAIL" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0

/* testbench/linear_parser_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module linear_parser_tb;

	localparam int WAIT_LIMIT = 300; // cycles allowed for any single wait

	logic clk;
	logic reset;
	logic clk_en;
	logic trigger;
	gparse_pkg::move_kind_t move_kind;
	logic [7:0] char_data;
	logic char_strobe;
	logic char_ready;
	logic rdy;
	logic done;
	gparse_pkg::move_kind_t opcode_kind;
	logic [gparse_pkg::COORD_W-1:0] opcode_x;
	logic [gparse_pkg::COORD_W-1:0] opcode_y;
	logic [gparse_pkg::COORD_W-1:0] pos_x;
	logic [gparse_pkg::COORD_W-1:0] pos_y;
	logic parse_success;
	logic parse_newline;

	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	int model_pos_x = 0; // tool position as the model sees it
	int model_pos_y = 0;

	linear_parser_top u_linear_parser_top (
		.clk(clk),
		.reset(reset),
		.clk_en(clk_en),
		.trigger(trigger),
		.move_kind(move_kind),
		.char_data(char_data),
		.char_strobe(char_strobe),
		.char_ready(char_ready),
		.rdy(rdy),
		.done(done),
		.opcode_kind(opcode_kind),
		.opcode_x(opcode_x),
		.opcode_y(opcode_y),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.parse_success(parse_success),
		.parse_newline(parse_newline)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic end_run();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation finished: PASS");
		end
		else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// polls rdy on falling edges until it reaches the given level
	task automatic wait_rdy(input logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (rdy !== level) begin
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("timeout: rdy never went to %0b", level);
				timeouts++;
				end_run();
			end
			@(negedge clk);
		end
	endtask

	task automatic wait_char_ready();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (char_ready !== 1'b1) begin
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("timeout: the character slot was never freed");
				timeouts++;
				end_run();
			end
			@(negedge clk);
		end
	endtask

	task automatic send_line(input string line, input int count);
		for (int i = 0; i < count; i++) begin
			repeat ($urandom % 3) @(posedge clk); // random gap between characters
			wait_char_ready();
			@(posedge clk);
			char_data <= line[i];
			char_strobe <= 1'b1;
			@(posedge clk);
			char_strobe <= 1'b0;
		end
	endtask

	// tokenizes one titled argument by the parsing rules
	function automatic void model_arg(input string s, input int start, input byte title,
		output int next, output bit ok, output bit nl, output bit big, output int val);
		int i;
		bit seen;
		bit in_digits;
		bit fin;
		byte c;
		i = start;
		ok = 0;
		nl = 0;
		big = 0;
		val = 0;
		seen = 0;
		in_digits = 0;
		fin = 0;
		while (!fin && i < s.len()) begin
			c = s[i];
			i++;
			if (!in_digits) begin
				if (c == title) in_digits = 1;
				else if (c == 8'h0a) begin
					nl = 1;
					fin = 1;
				end
				else if (c != 8'h20) fin = 1; // wrong title or junk
			end
			else if (c >= 8'h30 && c <= 8'h39) begin
				seen = 1;
				val = val * 10 + (int'(c) - 48);
				if (val > 4095) big = 1;
				if (val > 65535) val = 65535;
			end
			else if (c == 8'h20) begin
				ok = seen;
				fin = 1;
			end
			else if (c == 8'h0a) begin
				ok = seen;
				nl = 1;
				fin = 1;
			end
			else fin = 1;
		end
		next = i;
	endfunction

	task automatic run_parse(input string line, input gparse_pkg::move_kind_t kind);
		int nx;
		int ny;
		int xval;
		int yval;
		int used;
		int exp_x;
		int exp_y;
		bit xok;
		bit xnl;
		bit xbig;
		bit yok;
		bit ynl;
		bit ybig;
		bit exp_ok;
		bit exp_nl;
		model_arg(line, 0, 8'h58, nx, xok, xnl, xbig, xval);
		used = nx; // only what the parser reads is sent
		exp_ok = 0;
		exp_nl = xnl;
		exp_x = 0;
		exp_y = 0;
		if (xok && !xnl && !xbig) begin
			exp_x = xval;
			model_arg(line, nx, 8'h59, ny, yok, ynl, ybig, yval);
			used = ny;
			exp_nl = ynl;
			if (yok && !ybig) begin
				exp_ok = 1;
				exp_y = yval;
			end
		end
		if (exp_ok) begin
			model_pos_x = exp_x;
			model_pos_y = exp_y;
		end
		wait_rdy(1'b1);
		@(posedge clk);
		trigger <= 1'b1;
		move_kind <= kind;
		@(posedge clk);
		trigger <= 1'b0;
		wait_rdy(1'b0);
		send_line(line, used);
		wait_rdy(1'b1);
		check_value("done", done, 1);
		check_value("opcode_kind", int'(opcode_kind), int'(kind));
		check_value("opcode_x", opcode_x, exp_x);
		check_value("opcode_y", opcode_y, exp_y);
		check_value("parse_success", parse_success, exp_ok);
		check_value("parse_newline", parse_newline, exp_nl);
		check_value("pos_x", pos_x, model_pos_x);
		check_value("pos_y", pos_y, model_pos_y);
	endtask

	// trigger held while the clock enable is off must not start anything
	task automatic gated_trigger();
		int old_x;
		int old_y;
		int old_ok;
		int old_ox;
		int old_oy;
		old_x = pos_x;
		old_y = pos_y;
		old_ok = parse_success;
		old_ox = opcode_x;
		old_oy = opcode_y;
		@(posedge clk);
		clk_en <= 1'b0;
		trigger <= 1'b1;
		repeat (6) begin
			@(negedge clk);
			check_value("rdy", rdy, 1);
			check_value("pos_x", pos_x, old_x);
			check_value("pos_y", pos_y, old_y);
			check_value("parse_success", parse_success, old_ok);
			check_value("opcode_x", opcode_x, old_ox);
			check_value("opcode_y", opcode_y, old_oy);
		end
		@(posedge clk);
		trigger <= 1'b0;
		clk_en <= 1'b1;
		@(negedge clk);
		check_value("rdy", rdy, 1);
	endtask

	initial begin
		string line;
		int xv;
		int yv;
		gparse_pkg::move_kind_t kind;
		void'($urandom(32'ha189bb83));
		reset <= 1'b1;
		clk_en <= 1'b1;
		trigger <= 1'b0;
		move_kind <= gparse_pkg::MOVE_RAPID;
		char_data <= 8'h00;
		char_strobe <= 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("rdy", rdy, 1);
		check_value("done", done, 1);
		check_value("char_ready", char_ready, 1);
		check_value("parse_success", parse_success, 0);
		check_value("pos_x", pos_x, 0);
		check_value("pos_y", pos_y, 0);

		run_parse("X12 Y345 ", gparse_pkg::MOVE_LINEAR);
		run_parse("X7\n", gparse_pkg::MOVE_RAPID);
		run_parse("X5000 Y1 ", gparse_pkg::MOVE_LINEAR);
		run_parse("Y3 X4 ", gparse_pkg::MOVE_LINEAR);
		for (int n = 0; n < 12; n++) begin
			xv = $urandom % 4096;
			yv = $urandom % 4096;
			line = $sformatf("X%0d Y%0d", xv, yv);
			if ($urandom % 2) line = {line, "\n"};
			else line = {line, " "};
			if ($urandom % 3 == 0) line = {"  ", line}; // leading spaces are skipped
			kind = gparse_pkg::move_kind_t'($urandom % 2);
			run_parse(line, kind);
		end
		gated_trigger();
		run_parse("X4095 Y0\n", gparse_pkg::MOVE_RAPID);
		end_run();
	end

endmodule : linear_parser_tb

`default_nettype wire

/* source/linear_parser_top.sv */
`timescale 1ns/10ps
`default_nettype none

module linear_parser_top (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic trigger,
	input gparse_pkg::move_kind_t move_kind,
	input logic [7:0] char_data,
	input logic char_strobe,
	output logic char_ready,
	output logic rdy,
	output logic done,
	output gparse_pkg::move_kind_t opcode_kind,
	output logic [gparse_pkg::COORD_W-1:0] opcode_x,
	output logic [gparse_pkg::COORD_W-1:0] opcode_y,
	output logic [gparse_pkg::COORD_W-1:0] pos_x,
	output logic [gparse_pkg::COORD_W-1:0] pos_y,
	output logic parse_success,
	output logic parse_newline
);

	logic char_take;
	logic char_pending;
	gparse_pkg::char_t char_class;
	logic [3:0] char_digit;

	gparse_pkg::char_t arg_title;
	logic arg_trigger;
	logic arg_rdy;
	logic arg_done;
	logic arg_success;
	logic arg_newline;
	logic arg_too_big;
	logic [gparse_pkg::COORD_W-1:0] arg_value;

	logic zero;
	logic set_cmd;
	logic set_x;
	logic set_y;
	logic update_pos;
	logic set_success;
	logic set_newline;

	char_decoder u_char_decoder (
		.clk(clk),
		.reset(reset),
		.clk_en(clk_en),
		.char_data(char_data),
		.char_strobe(char_strobe),
		.char_take(char_take),
		.char_ready(char_ready),
		.char_pending(char_pending),
		.char_class(char_class),
		.char_digit(char_digit)
	);

	arg_parser u_arg_parser (
		.clk(clk),
		.reset(reset),
		.clk_en(clk_en),
		.arg_trigger(arg_trigger),
		.arg_title(arg_title),
		.char_pending(char_pending),
		.char_class(char_class),
		.char_digit(char_digit),
		.char_take(char_take),
		.arg_rdy(arg_rdy),
		.arg_done(arg_done),
		.arg_success(arg_success),
		.arg_newline(arg_newline),
		.arg_too_big(arg_too_big),
		.arg_value(arg_value)
	);

	linear_subparser_fsm u_linear_subparser_fsm (
		.clk(clk),
		.reset(reset),
		.clk_en(clk_en),
		.trigger(trigger),
		.arg_done(arg_done),
		.arg_rdy(arg_rdy),
		.arg_success(arg_success),
		.arg_newline(arg_newline),
		.arg_too_big(arg_too_big),
		.zero(zero),
		.set_cmd(set_cmd),
		.arg_title(arg_title),
		.arg_trigger(arg_trigger),
		.set_x(set_x),
		.set_y(set_y),
		.update_pos(update_pos),
		.set_success(set_success),
		.set_newline(set_newline),
		.done(done),
		.rdy(rdy)
	);

	move_result u_move_result (
		.clk(clk),
		.reset(reset),
		.clk_en(clk_en),
		.zero(zero),
		.set_cmd(set_cmd),
		.set_x(set_x),
		.set_y(set_y),
		.update_pos(update_pos),
		.set_success(set_success),
		.set_newline(set_newline),
		.move_kind(move_kind),
		.arg_value(arg_value),
		.opcode_kind(opcode_kind),
		.opcode_x(opcode_x),
		.opcode_y(opcode_y),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.parse_success(parse_success),
		.parse_newline(parse_newline)
	);

endmodule : linear_parser_top

`default_nettype wire

/* source/move_result.sv */
`timescale 1ns/10ps
`default_nettype none

module move_result (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic zero,
	input logic set_cmd,
	input logic set_x,
	input logic set_y,
	input logic update_pos,
	input logic set_success,
	input logic set_newline,
	input gparse_pkg::move_kind_t move_kind,
	input logic [gparse_pkg::COORD_W-1:0] arg_value,
	output gparse_pkg::move_kind_t opcode_kind,
	output logic [gparse_pkg::COORD_W-1:0] opcode_x,
	output logic [gparse_pkg::COORD_W-1:0] opcode_y,
	output logic [gparse_pkg::COORD_W-1:0] pos_x,
	output logic [gparse_pkg::COORD_W-1:0] pos_y,
	output logic parse_success,
	output logic parse_newline
);

	always_ff @(posedge clk) begin
		if (reset) begin
			opcode_kind <= gparse_pkg::MOVE_RAPID;
			opcode_x <= '0;
			opcode_y <= '0;
			pos_x <= '0;
			pos_y <= '0;
			parse_success <= 1'b0;
			parse_newline <= 1'b0;
		end
		else if (clk_en) begin
			if (zero) begin
				opcode_kind <= gparse_pkg::MOVE_RAPID; // position survives a new parse
				opcode_x <= '0;
				opcode_y <= '0;
				parse_success <= 1'b0;
				parse_newline <= 1'b0;
			end
			if (set_cmd) opcode_kind <= move_kind;
			if (set_x) opcode_x <= arg_value;
			if (set_y) opcode_y <= arg_value;
			if (update_pos) begin
				pos_x <= opcode_x; // only reached on a full success
				pos_y <= opcode_y;
			end
			if (set_success) parse_success <= 1'b1;
			if (set_newline) parse_newline <= 1'b1;
		end
	end

endmodule : move_result

`default_nettype wire

/* source/linear_subparser_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module linear_subparser_fsm (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic trigger,
	input logic arg_done,
	input logic arg_rdy,
	input logic arg_success,
	input logic arg_newline,
	input logic arg_too_big,
	output logic zero,
	output logic set_cmd,
	output gparse_pkg::char_t arg_title,
	output logic arg_trigger,
	output logic set_x,
	output logic set_y,
	output logic update_pos,
	output logic set_success,
	output logic set_newline,
	output logic done,
	output logic rdy
);

	typedef enum logic [4:0] {
		IDLE,
		ZERO,
		SET_CMD,
		PARSE_X_WAIT_RDY,
		PARSE_X_TRIGGER,
		PARSE_X_WAIT_DONE,
		PARSE_X_CHECK,
		SET_X,
		PARSE_Y_WAIT_RDY,
		PARSE_Y_TRIGGER,
		PARSE_Y_WAIT_DONE,
		PARSE_Y_CHECK,
		SET_Y,
		UPDATE_POS,
		SET_NEWLINE_AND_CONTINUE,
		SET_NEWLINE_AND_FAIL,
		SET_SUCCESS,
		DONE
	} lin_state_t;

	lin_state_t cur_state;
	lin_state_t nxt_state;

	always_comb begin
		nxt_state = cur_state;
		zero = 1'b0;
		set_cmd = 1'b0;
		arg_title = gparse_pkg::CHAR_UNKNOWN;
		arg_trigger = 1'b0;
		set_x = 1'b0;
		set_y = 1'b0;
		update_pos = 1'b0;
		set_success = 1'b0;
		set_newline = 1'b0;
		done = 1'b0;
		rdy = 1'b0;

		case (cur_state)
			IDLE: begin
				rdy = 1'b1;
				done = !trigger; // drops as soon as a parse starts
				if (trigger) nxt_state = ZERO;
			end
			ZERO: begin
				zero = 1'b1;
				nxt_state = SET_CMD;
			end
			SET_CMD: begin
				set_cmd = 1'b1;
				nxt_state = PARSE_X_WAIT_RDY;
			end
			PARSE_X_WAIT_RDY: begin
				arg_title = gparse_pkg::CHAR_X;
				if (arg_rdy) nxt_state = PARSE_X_TRIGGER;
			end
			PARSE_X_TRIGGER: begin
				arg_title = gparse_pkg::CHAR_X;
				arg_trigger = 1'b1; // held until the parser leaves idle
				if (!arg_rdy) nxt_state = PARSE_X_WAIT_DONE;
			end
			PARSE_X_WAIT_DONE: begin
				arg_title = gparse_pkg::CHAR_X;
				if (arg_done) nxt_state = PARSE_X_CHECK;
			end
			PARSE_X_CHECK: begin
				arg_title = gparse_pkg::CHAR_X;
				// a line that ends after X has no Y, so it cannot succeed
				if (arg_success && !arg_newline && !arg_too_big) nxt_state = SET_X;
				else if (arg_newline) nxt_state = SET_NEWLINE_AND_FAIL;
				else nxt_state = DONE;
			end
			SET_X: begin
				set_x = 1'b1;
				nxt_state = PARSE_Y_WAIT_RDY;
			end
			PARSE_Y_WAIT_RDY: begin
				arg_title = gparse_pkg::CHAR_Y;
				if (arg_rdy) nxt_state = PARSE_Y_TRIGGER;
			end
			PARSE_Y_TRIGGER: begin
				arg_title = gparse_pkg::CHAR_Y;
				arg_trigger = 1'b1;
				if (!arg_rdy) nxt_state = PARSE_Y_WAIT_DONE;
			end
			PARSE_Y_WAIT_DONE: begin
				arg_title = gparse_pkg::CHAR_Y;
				if (arg_done) nxt_state = PARSE_Y_CHECK;
			end
			PARSE_Y_CHECK: begin
				arg_title = gparse_pkg::CHAR_Y;
				if (arg_success && !arg_too_big) begin
					nxt_state = arg_newline ? SET_NEWLINE_AND_CONTINUE : SET_Y;
				end
				else if (arg_newline) nxt_state = SET_NEWLINE_AND_FAIL;
				else nxt_state = DONE;
			end
			SET_Y: begin
				set_y = 1'b1;
				nxt_state = UPDATE_POS;
			end
			UPDATE_POS: begin
				update_pos = 1'b1; // opcode x/y are settled by now
				nxt_state = SET_SUCCESS;
			end
			SET_NEWLINE_AND_CONTINUE: begin
				set_newline = 1'b1;
				nxt_state = SET_Y;
			end
			SET_NEWLINE_AND_FAIL: begin
				set_newline = 1'b1;
				nxt_state = DONE;
			end
			SET_SUCCESS: begin
				set_success = 1'b1;
				nxt_state = DONE;
			end
			DONE: begin
				done = 1'b1;
				nxt_state = IDLE;
			end
			default: nxt_state = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cur_state <= IDLE;
		end
		else if (clk_en) begin
			cur_state <= nxt_state;
		end
	end

endmodule : linear_subparser_fsm

`default_nettype wire

/* source/arg_parser.sv */
`timescale 1ns/10ps
`default_nettype none

module arg_parser (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic arg_trigger,
	input gparse_pkg::char_t arg_title,
	input logic char_pending,
	input gparse_pkg::char_t char_class,
	input logic [3:0] char_digit,
	output logic char_take,
	output logic arg_rdy,
	output logic arg_done,
	output logic arg_success,
	output logic arg_newline,
	output logic arg_too_big,
	output logic [gparse_pkg::COORD_W-1:0] arg_value
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SEEK,
		ST_DIGITS,
		ST_DONE
	} arg_state_t;

	arg_state_t state;
	logic [gparse_pkg::ACC_W-1:0] acc;
	logic [gparse_pkg::ACC_W+3:0] acc_next;
	logic digit_seen;

	// next accumulator value acc * 10 + digit with four spare bits
	assign acc_next = ({4'd0, acc} * (gparse_pkg::ACC_W + 4)'(10))
		+ (gparse_pkg::ACC_W + 4)'(char_digit);

	assign char_take = char_pending && (state == ST_SEEK || state == ST_DIGITS);
	assign arg_rdy = (state == ST_IDLE);
	assign arg_done = (state == ST_DONE);
	assign arg_value = arg_too_big ? (gparse_pkg::COORD_W)'(gparse_pkg::COORD_MAX)
		: acc[gparse_pkg::COORD_W-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			acc <= '0;
			digit_seen <= 1'b0;
			arg_success <= 1'b0;
			arg_newline <= 1'b0;
			arg_too_big <= 1'b0;
		end
		else if (clk_en) begin
			case (state)
				ST_IDLE: begin
					if (arg_trigger) begin
						state <= ST_SEEK;
						acc <= '0;
						digit_seen <= 1'b0;
						arg_success <= 1'b0; // flags live until the next trigger
						arg_newline <= 1'b0;
						arg_too_big <= 1'b0;
					end
				end
				ST_SEEK: begin
					if (char_pending) begin
						if (char_class == arg_title) begin
							state <= ST_DIGITS;
						end
						else if (char_class == gparse_pkg::CHAR_NEWLINE) begin
							arg_newline <= 1'b1; // line ended before the title
							state <= ST_DONE;
						end
						else if (char_class != gparse_pkg::CHAR_SPACE) begin
							state <= ST_DONE; // wrong title
						end
					end
				end
				ST_DIGITS: begin
					if (char_pending) begin
						case (char_class)
							gparse_pkg::CHAR_DIGIT: begin
								digit_seen <= 1'b1;
								if (|acc_next[gparse_pkg::ACC_W+3:gparse_pkg::ACC_W]) begin
									acc <= '1; // saturate
								end
								else begin
									acc <= acc_next[gparse_pkg::ACC_W-1:0];
								end
								if (acc_next > gparse_pkg::COORD_MAX) begin
									arg_too_big <= 1'b1;
								end
							end
							gparse_pkg::CHAR_SPACE: begin
								arg_success <= digit_seen;
								state <= ST_DONE;
							end
							gparse_pkg::CHAR_NEWLINE: begin
								arg_success <= digit_seen;
								arg_newline <= 1'b1;
								state <= ST_DONE;
							end
							default: state <= ST_DONE; // junk inside the number
						endcase
					end
				end
				default: state <= ST_IDLE; // done pulse is one cycle
			endcase
		end
	end

endmodule : arg_parser

`default_nettype wire

/* source/char_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module char_decoder (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic [7:0] char_data,
	input logic char_strobe,
	input logic char_take,
	output logic char_ready,
	output logic char_pending,
	output gparse_pkg::char_t char_class,
	output logic [3:0] char_digit
);

	logic [7:0] held_byte;

	always_ff @(posedge clk) begin
		if (reset) begin
			char_pending <= 1'b0;
		end
		else if (clk_en) begin
			if (char_take) begin
				char_pending <= 1'b0; // consumed so the slot is free again
				held_byte <= 8'h00;
			end
			else if (char_strobe && !char_pending) begin
				char_pending <= 1'b1;
				held_byte <= char_data;
			end
		end
	end

	assign char_ready = !char_pending; // strobes while full are dropped

	always_comb begin
		char_digit = 4'd0;
		case (held_byte) inside
			8'h58: char_class = gparse_pkg::CHAR_X; // 'X'
			8'h59: char_class = gparse_pkg::CHAR_Y; // 'Y'
			8'h20: char_class = gparse_pkg::CHAR_SPACE;
			8'h0a: char_class = gparse_pkg::CHAR_NEWLINE; // line feed
			[8'h30:8'h39]: begin
				char_class = gparse_pkg::CHAR_DIGIT;
				char_digit = held_byte[3:0]; // ascii digits carry value in low nibble
			end
			default: char_class = gparse_pkg::CHAR_UNKNOWN;
		endcase
	end

endmodule : char_decoder

`default_nettype wire

/* source/gparse_pkg.sv */
`default_nettype none

package gparse_pkg;

	// width of one opcode coordinate field
	localparam int COORD_W = 12;
	localparam int COORD_MAX = 4095; // largest value that fits COORD_W

	// extra headroom so an oversized number is seen before it wraps
	localparam int ACC_W = 16;

	typedef enum logic [2:0] {
		CHAR_UNKNOWN = 3'd0,
		CHAR_X = 3'd1,
		CHAR_Y = 3'd2,
		CHAR_DIGIT = 3'd3,
		CHAR_SPACE = 3'd4,
		CHAR_NEWLINE = 3'd5
	} char_t;

	typedef enum logic [0:0] {
		MOVE_RAPID = 1'b0, // G0
		MOVE_LINEAR = 1'b1 // G1
	} move_kind_t;

endpackage : gparse_pkg

`default_nettype wire
